//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Data word width
`define CACHE_WORD_BITS      32

// Word select inside a line
`define CACHE_OFFSET_BITS    2
`define CACHE_LINE_WORDS     4

// 16 lines per bank
`define CACHE_INDEX_BITS     4
`define CACHE_TAG_BITS       4

// Tag and index together
`define CACHE_LINE_ADDR_BITS 8
`define CACHE_ADDR_BITS      10

// Whole line, all words side by side
`define CACHE_LINE_BITS      128

`endif

//--- verilog/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    // One data word
    typedef logic [`CACHE_WORD_BITS-1:0] cache_word_t;

    // Whole line, word 0 sits in the low bits
    typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

    // Line address seen either as a plain number or split into tag and index
    typedef union packed {
        logic [`CACHE_LINE_ADDR_BITS-1:0] raw;
        struct packed {
            logic [`CACHE_TAG_BITS-1:0]   tag;
            logic [`CACHE_INDEX_BITS-1:0] index;
        } fields;
    } line_addr_u;

endpackage

//--- verilog/tag_store.sv
`include "cache_params.svh"

module tag_store (
    input  logic                         clk,
    input  logic                         rst,

    // Lookup port
    input  logic [`CACHE_INDEX_BITS-1:0] read_index,
    output logic                         read_valid,
    output logic                         read_dirty,
    output logic [`CACHE_TAG_BITS-1:0]   read_tag,

    // Update port
    input  logic                         do_fill,
    input  logic                         do_write,
    input  logic [`CACHE_INDEX_BITS-1:0] write_index,
    input  logic [`CACHE_TAG_BITS-1:0]   write_tag
);

    localparam int NUM_LINES = 1 << `CACHE_INDEX_BITS;

    logic [NUM_LINES-1:0]       valid_bits;
    logic [NUM_LINES-1:0]       dirty_bits;
    logic [`CACHE_TAG_BITS-1:0] tags [NUM_LINES];

    // State flags per line
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (do_fill) begin
            // A fresh line comes in clean
            valid_bits[write_index] <= 1'b1;
            // Refilling the line already held keeps its dirty bit
            if (!(valid_bits[write_index] && tags[write_index] == write_tag)) begin
                dirty_bits[write_index] <= 1'b0;
            end
        end else if (do_write) begin
            dirty_bits[write_index] <= 1'b1;
        end
    end

    // Tag only changes when a line is filled
    always_ff @(posedge clk) begin
        if (do_fill) begin
            tags[write_index] <= write_tag;
        end
    end

    // Lookup is combinational
    assign read_valid = valid_bits[read_index];
    assign read_dirty = dirty_bits[read_index];
    assign read_tag   = tags[read_index];

endmodule

//--- verilog/tag_access.sv
`include "cache_params.svh"

module tag_access
    import cache_pkg::*;
#(
    parameter bit WRITE_ENABLE = 1
) (
    input  logic                       clk,
    input  logic                       rst,

    // Operation for this cycle
    input  logic                       valid,
    input  line_addr_u                 addr,
    input  logic                       is_write,
    input  logic                       is_fill,

    // Lookup result
    output logic [`CACHE_TAG_BITS-1:0] read_tag,
    output logic                       miss,
    output logic                       dirty,
    output logic                       write_en
);

    logic                       entry_valid;
    logic                       entry_dirty;
    logic [`CACHE_TAG_BITS-1:0] entry_tag;
    logic                       tags_match;
    logic                       do_fill;
    logic                       do_write;

    tag_store u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .read_index  (addr.fields.index),
        .read_valid  (entry_valid),
        .read_dirty  (entry_dirty),
        .read_tag    (entry_tag),
        .do_fill     (do_fill),
        .do_write    (do_write),
        .write_index (addr.fields.index),
        .write_tag   (addr.fields.tag)
    );

    // Stored tag only counts when the entry holds a line
    assign tags_match = entry_valid && (entry_tag == addr.fields.tag);

    // Writes only land on a hit
    assign do_write = WRITE_ENABLE && valid && !is_fill && is_write && tags_match;
    assign do_fill  = valid && is_fill;

    assign miss = valid && !is_fill && !tags_match;

    // A fill over the same tag keeps the line, so nothing is evicted
    assign dirty = WRITE_ENABLE && valid && entry_valid && entry_dirty
                && !(is_fill && tags_match);

    // Redundant fills leave the data alone
    assign write_en = do_write || (do_fill && !tags_match);

    assign read_tag = entry_tag;

endmodule

//--- verilog/data_store.sv
`include "cache_params.svh"

module data_store
    import cache_pkg::*;
(
    input  logic                          clk,
    input  logic [`CACHE_INDEX_BITS-1:0]  index,

    // Whole line write from the memory side
    input  logic                          fill_en,
    input  cache_line_t                   fill_data,

    // Single word write from the client
    input  logic                          word_en,
    input  logic [`CACHE_OFFSET_BITS-1:0] word_sel,
    input  cache_word_t                   word_data,

    output cache_line_t                   read_line
);

    localparam int NUM_LINES = 1 << `CACHE_INDEX_BITS;

    cache_line_t lines [NUM_LINES];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            lines[index] <= fill_data;
        end else if (word_en) begin
            lines[index][word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] <= word_data;
        end
    end

    // Asynchronous read, the bank registers what it needs
    assign read_line = lines[index];

endmodule

//--- verilog/cache_bank.sv
`include "cache_params.svh"

module cache_bank
    import cache_pkg::*;
#(
    parameter bit WRITE_ENABLE = 1
) (
    input  logic                             clk,
    input  logic                             rst,

    // Client request
    input  logic                             req_valid,
    input  logic [`CACHE_ADDR_BITS-1:0]      req_addr,
    input  logic                             req_write,
    input  cache_word_t                      req_wdata,

    // Line fill from memory
    input  logic                             fill_valid,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0] fill_addr,
    input  cache_line_t                      fill_data,

    // Response, one cycle after the request
    output logic                             rsp_valid,
    output logic                             rsp_hit,
    output cache_word_t                      rsp_rdata,

    // Dirty victim handed back to memory
    output logic                             wb_valid,
    output logic [`CACHE_LINE_ADDR_BITS-1:0] wb_addr,
    output cache_line_t                      wb_data
);

    line_addr_u                       lookup_addr;
    logic [`CACHE_OFFSET_BITS-1:0]    word_sel;
    logic [`CACHE_TAG_BITS-1:0]       victim_tag;
    logic                             lookup_miss;
    logic                             lookup_dirty;
    logic                             data_we;
    cache_line_t                      line_rd;
    cache_word_t                      word_rd;
    logic                             wb_due;

    // Fill owns the lookup while it is present
    assign lookup_addr.raw = fill_valid ? fill_addr
                                        : req_addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
    assign word_sel = req_addr[`CACHE_OFFSET_BITS-1:0];

    tag_access #(
        .WRITE_ENABLE (WRITE_ENABLE)
    ) u_tag_access (
        .clk      (clk),
        .rst      (rst),
        .valid    (req_valid || fill_valid),
        .addr     (lookup_addr),
        .is_write (req_write),
        .is_fill  (fill_valid),
        .read_tag (victim_tag),
        .miss     (lookup_miss),
        .dirty    (lookup_dirty),
        .write_en (data_we)
    );

    data_store u_data_store (
        .clk       (clk),
        .index     (lookup_addr.fields.index),
        .fill_en   (data_we && fill_valid),
        .fill_data (fill_data),
        .word_en   (data_we && !fill_valid),
        .word_sel  (word_sel),
        .word_data (req_wdata),
        .read_line (line_rd)
    );

    assign word_rd = line_rd[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

    // Only a request miss can evict, fills never do
    assign wb_due = req_valid && lookup_miss && lookup_dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            wb_valid  <= wb_due;
        end
    end

    always_ff @(posedge clk) begin
        rsp_hit   <= req_valid && !lookup_miss;
        // Zero unless this is a read hit
        rsp_rdata <= (req_valid && !req_write && !lookup_miss) ? word_rd : '0;
        if (wb_due) begin
            wb_addr <= {victim_tag, lookup_addr.fields.index};
            wb_data <= line_rd;
        end
    end

endmodule

//--- tb/cache_bank_assert.sv
module cache_bank_assert (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic fill_valid,
    input logic rsp_valid,
    input logic rsp_hit,
    input logic wb_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Each request is answered on the next cycle, and a response needs a request
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
        req_valid |=> rsp_valid)
        else $error("rsp_valid did not follow req_valid");
    a_rsp_needs_req: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> $past(req_valid))
        else $error("rsp_valid without a request in the previous cycle");

    // A writeback only rides along with a missed response
    a_wb_on_miss: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (rsp_valid && !rsp_hit))
        else $error("wb_valid without a missed response");

    a_req_fill_apart: assert property (@(posedge clk) disable iff (rst)
        !(req_valid && fill_valid))
        else $error("req_valid and fill_valid high in the same cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |=> (!rsp_valid && !wb_valid))
        else $error("rsp_valid or wb_valid high after a reset cycle");

endmodule

//--- tb/cache_bank_checker.sv
`include "cache_params.svh"

module cache_bank_checker
    import cache_pkg::*;
(
    input  logic                             clk,

    // Expected response for the request answered this cycle
    input  logic                             exp_valid,
    input  int                               exp_id,
    input  logic                             exp_hit,
    input  cache_word_t                      exp_rdata,
    input  logic                             exp_wb,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0] exp_wb_addr,
    input  cache_line_t                      exp_wb_data,
    input  logic                             report_counts,

    // DUT outputs
    input  logic                             rsp_valid,
    input  logic                             rsp_hit,
    input  cache_word_t                      rsp_rdata,
    input  logic                             wb_valid,
    input  logic [`CACHE_LINE_ADDR_BITS-1:0] wb_addr,
    input  cache_line_t                      wb_data,

    output int                               error_count,
    output int                               test_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors = 0;
    int tests  = 0;
    int failed = 0;

    assign error_count = errors;
    assign test_count  = tests;

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        int errs;
        errs = 0;
        if (exp_valid) begin
            if (!rsp_valid) begin
                $display("Error at %0t: test %0d got no response from the DUT", $time, exp_id);
                errs++;
            end else begin
                if (rsp_hit !== exp_hit) begin
                    $display("MISMATCH at %0t: test %0d rsp_hit %0b, expected %0b",
                             $time, exp_id, rsp_hit, exp_hit);
                    errs++;
                end
                if (rsp_rdata !== exp_rdata) begin
                    $display("MISMATCH at %0t: test %0d rsp_rdata %h, expected %h",
                             $time, exp_id, rsp_rdata, exp_rdata);
                    errs++;
                end
                if (wb_valid !== exp_wb) begin
                    $display("MISMATCH at %0t: test %0d wb_valid %0b, expected %0b",
                             $time, exp_id, wb_valid, exp_wb);
                    errs++;
                end else if (exp_wb && (wb_addr !== exp_wb_addr || wb_data !== exp_wb_data)) begin
                    $display("MISMATCH at %0t: test %0d writeback %h:%h, expected %h:%h",
                             $time, exp_id, wb_addr, wb_data, exp_wb_addr, exp_wb_data);
                    errs++;
                end
            end
            tests++;
            if (errs == 0) begin
                $display("Test %0d passed", exp_id);
            end else begin
                failed++;
                $display("Test %0d failed with %0d errors", exp_id, errs);
            end
        end else if (rsp_valid) begin
            $display("Error at %0t: the DUT responded with no request pending", $time);
            errs++;
        end
        errors += errs;
        if (report_counts) begin
            $display("Checked %0d tests, %0d passed, %0d failed, %0d errors",
                     tests, tests - failed, failed, errors);
        end
    end

endmodule

//--- tb/cache_bank_tb.sv
`include "cache_params.svh"

module cache_bank_tb
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_FILL     = 0;
    localparam int OP_READ     = 1;
    localparam int OP_WRITE    = 2;
    localparam int OP_RESET    = 3;
    localparam int MAX_ENTRIES = 32;
    localparam int NUM_LINES   = 1 << `CACHE_INDEX_BITS;
    localparam int WB          = `CACHE_WORD_BITS;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             req_valid;
    logic [`CACHE_ADDR_BITS-1:0]      req_addr;
    logic                             req_write;
    cache_word_t                      req_wdata;
    logic                             fill_valid;
    logic [`CACHE_LINE_ADDR_BITS-1:0] fill_addr;
    cache_line_t                      fill_data;
    logic                             rsp_valid;
    logic                             rsp_hit;
    cache_word_t                      rsp_rdata;
    logic                             wb_valid;
    logic [`CACHE_LINE_ADDR_BITS-1:0] wb_addr;
    cache_line_t                      wb_data;

    // Expected response passed to the checker
    logic                             exp_valid;
    int                               exp_id;
    logic                             exp_hit;
    cache_word_t                      exp_rdata;
    logic                             exp_wb;
    logic [`CACHE_LINE_ADDR_BITS-1:0] exp_wb_addr;
    cache_line_t                      exp_wb_data;
    logic                             report_counts;
    int                               error_count;
    int                               test_count;

    // Stimulus table, one row per operation
    int                               tbl_op      [MAX_ENTRIES];
    logic [`CACHE_ADDR_BITS-1:0]      tbl_addr    [MAX_ENTRIES];
    cache_word_t                      tbl_data    [MAX_ENTRIES];
    logic                             tbl_hit     [MAX_ENTRIES];
    logic                             tbl_wb      [MAX_ENTRIES];
    logic [`CACHE_LINE_ADDR_BITS-1:0] tbl_wb_addr [MAX_ENTRIES];
    int                               num_entries  = 0;
    int                               num_requests = 0;

    // Model of what each line should hold
    cache_line_t                      shadow_line [NUM_LINES];
    logic [`CACHE_TAG_BITS-1:0]       shadow_tag  [NUM_LINES];
    logic [NUM_LINES-1:0]             shadow_valid;

    logic [31:0]                      lfsr_state;
    int                               cycle_count    = 0;
    int                               timeout_cycles = 1000;

    cache_bank DUT (.*);
    cache_bank_checker u_checker (.*);
    bind cache_bank cache_bank_assert u_assert (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_word(output cache_word_t word);
        word = '0;
        repeat (WB) begin
            word = {word[WB-2:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic add_entry(input int op, input logic [`CACHE_ADDR_BITS-1:0] addr,
                             input cache_word_t data, input logic hit, input logic wb,
                             input logic [`CACHE_LINE_ADDR_BITS-1:0] victim);
        tbl_op[num_entries]      = op;
        tbl_addr[num_entries]    = addr;
        tbl_data[num_entries]    = data;
        tbl_hit[num_entries]     = hit;
        tbl_wb[num_entries]      = wb;
        tbl_wb_addr[num_entries] = victim;
        if (op == OP_READ || op == OP_WRITE) begin
            num_requests++;
        end
        num_entries++;
    endtask

    task automatic build_table();
        // Empty cache, then a fill and all four words
        add_entry(OP_READ,  10'h14C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_FILL,  10'h14C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14C, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14D, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14E, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14F, 32'h0, 1'b1, 1'b0, 8'h00);
        // Write hit, then the line read back
        add_entry(OP_WRITE, 10'h14D, 32'hCAFE_0001, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14D, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14C, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h14E, 32'h0, 1'b1, 1'b0, 8'h00);
        // Conflict on the dirty line evicts it
        add_entry(OP_READ,  10'h28C, 32'h0, 1'b0, 1'b1, 8'h53);
        add_entry(OP_FILL,  10'h28C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h28E, 32'h0, 1'b1, 1'b0, 8'h00);
        // Clean conflict and a write miss
        add_entry(OP_READ,  10'h14C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_WRITE, 10'h14C, 32'hDEAD_BEEF, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h28C, 32'h0, 1'b1, 1'b0, 8'h00);
        // Same tag filled again over a dirty line
        add_entry(OP_FILL,  10'h09C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_WRITE, 10'h09E, 32'h5A5A_1234, 1'b1, 1'b0, 8'h00);
        add_entry(OP_FILL,  10'h09C, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h09E, 32'h0, 1'b1, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h09F, 32'h0, 1'b1, 1'b0, 8'h00);
        // Dirty bit survives the second fill and the line is evicted
        add_entry(OP_READ,  10'h25C, 32'h0, 1'b0, 1'b1, 8'h27);
        // Reset empties the whole bank
        add_entry(OP_RESET, 10'h000, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h09E, 32'h0, 1'b0, 1'b0, 8'h00);
        add_entry(OP_READ,  10'h28C, 32'h0, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic idle_inputs();
        rst        = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        fill_valid = 1'b0;
    endtask

    task automatic drive_entry(input int i);
        line_addr_u  la;
        cache_line_t line;
        cache_word_t word;
        int          k;
        la.raw = tbl_addr[i][`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
        case (tbl_op[i])
            OP_FILL: begin
                for (k = 0; k < `CACHE_LINE_WORDS; k++) begin
                    random_word(word);
                    line[k*WB +: WB] = word;
                end
                fill_valid = 1'b1;
                fill_addr  = la.raw;
                fill_data  = line;
                // Only a different tag replaces the data
                if (!(shadow_valid[la.fields.index] &&
                      shadow_tag[la.fields.index] == la.fields.tag)) begin
                    shadow_line[la.fields.index] = line;
                end
                shadow_valid[la.fields.index] = 1'b1;
                shadow_tag[la.fields.index]   = la.fields.tag;
            end
            OP_RESET: begin
                rst          = 1'b1;
                shadow_valid = '0;
            end
            default: begin
                req_valid = 1'b1;
                req_addr  = tbl_addr[i];
                req_write = (tbl_op[i] == OP_WRITE);
                req_wdata = tbl_data[i];
            end
        endcase
    endtask

    task automatic set_expected(input int i);
        logic [`CACHE_INDEX_BITS-1:0]  idx;
        logic [`CACHE_OFFSET_BITS-1:0] off;
        idx = tbl_addr[i][`CACHE_INDEX_BITS+`CACHE_OFFSET_BITS-1:`CACHE_OFFSET_BITS];
        off = tbl_addr[i][`CACHE_OFFSET_BITS-1:0];
        exp_valid   = (tbl_op[i] == OP_READ || tbl_op[i] == OP_WRITE);
        exp_id      = i;
        exp_hit     = tbl_hit[i];
        exp_wb      = tbl_wb[i];
        exp_wb_addr = tbl_wb_addr[i];
        exp_wb_data = shadow_line[idx];
        exp_rdata   = '0;
        if (tbl_op[i] == OP_READ && tbl_hit[i]) begin
            exp_rdata = shadow_line[idx][off*WB +: WB];
        end
        // A write hit changes one word of the line
        if (tbl_op[i] == OP_WRITE && tbl_hit[i]) begin
            shadow_line[idx][off*WB +: WB] = tbl_data[i];
        end
    endtask

    initial begin
        int n;
        idle_inputs();
        rst           = 1'b1;
        req_addr      = '0;
        req_wdata     = '0;
        fill_addr     = '0;
        fill_data     = '0;
        exp_valid     = 1'b0;
        exp_id        = 0;
        exp_hit       = 1'b0;
        exp_rdata     = '0;
        exp_wb        = 1'b0;
        exp_wb_addr   = '0;
        exp_wb_data   = '0;
        report_counts = 1'b0;
        shadow_valid  = '0;
        lfsr_state    = 32'd91462;
        build_table();
        timeout_cycles = 2 * num_entries + 20;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // One entry per cycle, then an idle cycle while the response is checked
        for (n = 0; n < num_entries; n++) begin
            @(posedge clk);
            #2;
            exp_valid = 1'b0;
            drive_entry(n);
            @(posedge clk);
            #2;
            idle_inputs();
            set_expected(n);
        end

        @(posedge clk);
        #2;
        exp_valid     = 1'b0;
        report_counts = 1'b1;
        @(posedge clk);
        #2;
        report_counts = 1'b0;
        if (test_count != num_requests) begin
            $display("Only %0d of %0d requests were checked", test_count, num_requests);
        end
        if (error_count == 0 && test_count == num_requests) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/cache_pkg.sv
verilog/tag_store.sv
verilog/tag_access.sv
verilog/data_store.sv
verilog/cache_bank.sv
tb/cache_bank_assert.sv
tb/cache_bank_checker.sv
tb/cache_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_bank_tb -f sources.f -o cache_bank_sim

# A failed assertion stops the simulator early, so the log decides the result
./obj_dir/cache_bank_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a final status line"
    exit 1
fi
